//--- Bender.yml
package:
  name: ts_replacer

sources:
  - ts_pkg.sv
  - replacer_pkg.sv
  - ts_header_decoder.sv
  - pid_match_unit.sv
  - packet_rewriter.sv
  - ts_replacer.sv
  - target: simulation
    files:
      - ts_replacer_tb.sv

//--- packet_rewriter.sv
`timescale 1ns/1ps

module packet_rewriter (
	input  logic clk,
	input  logic rst_n,
	input  logic base_data,
	input  ts_pkg::ts_beat_t delayed_beat,
	input  replacer_pkg::pkt_ctrl_t pkt_ctrl,
	input  logic load,
	input  logic data_write,
	input  replacer_pkg::data_addr_t data_index,
	input  replacer_pkg::data_word_t data_word,
	output ts_pkg::ts_beat_t ts_out
);
	import ts_pkg::*;
	import replacer_pkg::*;

	localparam int RAM_WORDS = DATA_GROUPS * GROUP_WORDS;

	data_word_t ram [RAM_WORDS];

	ts_pos_t count;
	ts_pos_t byte_idx;
	data_addr_t rd_addr;
	data_word_t rd_word;
	ts_byte_t ram_byte;
	ts_byte_t orig;
	ts_byte_t new_byte;
	logic pusi;
	logic in_pkt;
	logic emit;

	ts_byte_t out_data;
	logic out_sync;
	logic out_valid;

	always_ff @(posedge clk) begin
		if (data_write && (int'(data_index) < RAM_WORDS)) begin
			ram[data_index] <= data_word;
		end
	end

	// load restarts the packet on the sync byte that is about to leave the delay
	assign byte_idx = load ? '0 : count;
	assign in_pkt = byte_idx < ts_pos_t'(TS_PACKET_BYTES);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= ts_pos_t'(TS_PACKET_BYTES);
		end else if (delayed_beat.valid && in_pkt) begin
			count <= byte_idx + 1'b1;
		end else if (load) begin
			count <= '0;
		end
	end

	// four packet bytes per word, lowest byte first
	assign rd_addr = data_addr_t'(pkt_ctrl.group) * data_addr_t'(GROUP_WORDS)
		+ data_addr_t'(byte_idx[7:2]);
	assign rd_word = ram[rd_addr];
	assign ram_byte = rd_word[8*byte_idx[1:0] +: 8];

	assign orig = delayed_beat.data;
	assign pusi = (pkt_ctrl.group == '0);

	always_comb begin
		case (byte_idx)
			8'd1: begin
				new_byte = {orig[7], pusi, orig[5], pkt_ctrl.change ? ram_byte[4:0] : orig[4:0]};
			end
			8'd2: new_byte = pkt_ctrl.change ? ram_byte : orig;
			// adaptation field plus payload
			8'd3: new_byte = {orig[7:6], 2'b11, orig[3:0]};
			// pts fields with marker bits, group 0 only
			8'd24: new_byte = pusi ? {4'b0010, pkt_ctrl.pts[32:30], 1'b1} : orig;
			8'd25: new_byte = pusi ? pkt_ctrl.pts[29:22] : orig;
			8'd26: new_byte = pusi ? {pkt_ctrl.pts[21:15], 1'b1} : orig;
			8'd27: new_byte = pusi ? pkt_ctrl.pts[14:7] : orig;
			8'd28: new_byte = pusi ? {pkt_ctrl.pts[6:0], 1'b1} : orig;
			default: new_byte = ram_byte;
		endcase
	end

	assign emit = delayed_beat.valid && (base_data || (pkt_ctrl.keep && in_pkt));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= emit;
		end
	end

	// byte and sync hold between beats
	always_ff @(posedge clk) begin
		if (emit) begin
			out_data <= base_data ? orig : new_byte;
			out_sync <= delayed_beat.sync;
		end
	end

	assign ts_out = '{
		data: out_data,
		sync: out_sync,
		valid: out_valid
	};

endmodule

//--- pid_match_unit.sv
`timescale 1ns/1ps

module pid_match_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic match_enable,
	input  logic base_data,
	input  ts_pkg::ts_pkt_start_t start,
	input  logic pid_write,
	input  logic pts_write,
	input  replacer_pkg::slot_idx_t pid_index,
	input  replacer_pkg::pid_entry_t pid_data,
	input  replacer_pkg::pts_t pts_data,
	output replacer_pkg::pid_entry_t pid_readback,
	output replacer_pkg::pts_t pts_readback,
	output replacer_pkg::pkt_ctrl_t pkt_ctrl,
	output logic load,
	output logic matched_state,
	output logic [31:0] matched_count
);
	import replacer_pkg::*;

	pid_entry_t pid_table [PID_SLOTS];
	pts_t pts_val [PID_SLOTS];
	group_idx_t group_idx [PID_SLOTS];

	tick_cnt_t tick_cnt;
	logic tick;
	logic hit;
	slot_idx_t hit_slot;

	// software table writes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				pid_table[i] <= '0;
			end
		end else if (pid_write) begin
			pid_table[pid_index] <= pid_data;
		end
	end

	// free running tick for the pts counters
	assign tick = (tick_cnt == tick_cnt_t'(PTS_TICK_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// a write wins over the tick on its own slot only
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				pts_val[i] <= '0;
			end
		end else begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				if (pts_write && (pid_index == slot_idx_t'(i))) begin
					pts_val[i] <= pts_data;
				end else if (tick) begin
					pts_val[i] <= pts_val[i] + 1'b1;
				end
			end
		end
	end

	assign pid_readback = pid_table[pid_index];
	assign pts_readback = pts_val[pid_index];

	// lowest enabled slot with the header pid takes priority
	always_comb begin
		hit = 1'b0;
		hit_slot = '0;
		for (int i = PID_SLOTS - 1; i >= 0; i--) begin
			if (pid_table[i].match_en && (pid_table[i].pid == start.pid)) begin
				hit = 1'b1;
				hit_slot = slot_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pkt_ctrl <= '0;
			load <= 1'b0;
			matched_state <= 1'b0;
			matched_count <= '0;
			for (int i = 0; i < PID_SLOTS; i++) begin
				group_idx[i] <= '0;
			end
		end else begin
			load <= start.start;
			if (base_data) begin
				// pass-through, nothing counted or rotated
				pkt_ctrl.keep <= 1'b1;
				pkt_ctrl.change <= 1'b0;
			end else if (start.start) begin
				if (match_enable && hit) begin
					pkt_ctrl.keep <= 1'b1;
					pkt_ctrl.change <= pid_table[hit_slot].change_en;
					pkt_ctrl.group <= group_idx[hit_slot];
					pkt_ctrl.pts <= pts_val[hit_slot];
					if (group_idx[hit_slot] == group_idx_t'(DATA_GROUPS - 1)) begin
						group_idx[hit_slot] <= '0;
					end else begin
						group_idx[hit_slot] <= group_idx[hit_slot] + 1'b1;
					end
					matched_state <= 1'b1;
					matched_count <= matched_count + 1'b1;
				end else begin
					// unmatched packets are dropped
					pkt_ctrl.keep <= 1'b0;
					pkt_ctrl.change <= 1'b0;
					matched_state <= 1'b0;
				end
			end
		end
	end

endmodule

//--- replacer_pkg.sv
package replacer_pkg;

	// table and storage sizing
	localparam int PID_SLOTS = 4;
	localparam int DATA_GROUPS = 2;
	localparam int WORD_BYTES = 4;
	localparam int GROUP_WORDS = 47;

	// pts advances once per tick, 27 MHz / 90 kHz scaled to this clock
	localparam int PTS_TICK_CYCLES = 1389;

	typedef logic [1:0] slot_idx_t;
	typedef logic [0:0] group_idx_t;
	typedef logic [31:0] data_word_t;
	typedef logic [6:0] data_addr_t;
	typedef logic [32:0] pts_t;
	typedef logic [$clog2(PTS_TICK_CYCLES)-1:0] tick_cnt_t;

	// one pid table entry as seen by software
	typedef struct packed {
		ts_pkg::ts_pid_t pid;
		logic match_en;
		logic change_en;
	} pid_entry_t;

	// per-packet decision handed to the rewriter
	typedef struct packed {
		logic keep;
		logic change;
		group_idx_t group;
		pts_t pts;
	} pkt_ctrl_t;

endpackage

//--- ts_header_decoder.sv
`timescale 1ns/1ps

module ts_header_decoder (
	input  logic clk,
	input  logic rst_n,
	input  ts_pkg::ts_beat_t in,
	output ts_pkg::ts_beat_t delayed_beat,
	output ts_pkg::ts_pkt_start_t start
);
	import ts_pkg::*;

	// index 0 is the newest accepted byte, index 2 the oldest
	ts_byte_t dly_data [3];
	logic [2:0] dly_sync;

	logic sync_seen;
	ts_pid_t hdr_pid;

	// shift only on accepted bytes so gaps in valid stall the line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 3; i++) begin
				dly_data[i] <= '0;
			end
			dly_sync <= '0;
		end else if (in.valid) begin
			dly_data[0] <= in.data;
			dly_data[1] <= dly_data[0];
			dly_data[2] <= dly_data[1];
			dly_sync <= {dly_sync[1:0], in.sync};
		end
	end

	// sync byte sits one behind the pid bytes
	assign sync_seen = dly_sync[1] && (dly_data[1] == TS_SYNC_BYTE);

	// pid spans the low five bits of byte 1 and all of byte 2
	assign hdr_pid = {dly_data[0][4:0], in.data};

	assign start = '{
		start: in.valid && sync_seen,
		pid: hdr_pid
	};

	// oldest byte leaves with the current strobe so later stages stay aligned
	assign delayed_beat = '{
		data: dly_data[2],
		sync: dly_sync[2],
		valid: in.valid
	};

endmodule

//--- ts_pkg.sv
package ts_pkg;

	// mpeg-2 transport stream framing
	localparam int TS_PACKET_BYTES = 188;
	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;

	// one byte of the stream
	typedef logic [7:0] ts_byte_t;

	// 13-bit packet identifier from header bytes 1 and 2
	typedef logic [12:0] ts_pid_t;

	// byte position inside a packet, 0 to TS_PACKET_BYTES
	typedef logic [7:0] ts_pos_t;

	// stream beat, valid marks an accepted byte
	typedef struct packed {
		ts_byte_t data;
		logic sync;
		logic valid;
	} ts_beat_t;

	// header seen on the stream, pid already assembled
	typedef struct packed {
		logic start;
		ts_pid_t pid;
	} ts_pkt_start_t;

endpackage

//--- ts_replacer.f
ts_pkg.sv
replacer_pkg.sv
ts_header_decoder.sv
pid_match_unit.sv
packet_rewriter.sv
ts_replacer.sv
ts_replacer_tb.sv

//--- ts_replacer.sv
`timescale 1ns/1ps

module ts_replacer (
	input  logic clk,
	input  logic rst_n,
	input  ts_pkg::ts_beat_t ts_in,
	input  logic match_enable,
	input  logic base_data,
	input  logic pid_write,
	input  replacer_pkg::slot_idx_t pid_index,
	input  replacer_pkg::pid_entry_t pid_data,
	input  logic pts_write,
	input  replacer_pkg::pts_t pts_data,
	input  logic data_write,
	input  replacer_pkg::data_addr_t data_index,
	input  replacer_pkg::data_word_t data_word,
	output ts_pkg::ts_beat_t ts_out,
	output logic matched_state,
	output logic [31:0] matched_count,
	output replacer_pkg::pid_entry_t pid_readback,
	output replacer_pkg::pts_t pts_readback
);
	import ts_pkg::*;
	import replacer_pkg::*;

	ts_beat_t delayed_beat;
	ts_pkt_start_t start;
	pkt_ctrl_t pkt_ctrl;
	logic load;

	// decode: delay line and header detect
	ts_header_decoder decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in          (ts_in),
		.delayed_beat(delayed_beat),
		.start       (start)
	);

	// execute: pid lookup, pts and group rotation
	pid_match_unit execute_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.match_enable (match_enable),
		.base_data    (base_data),
		.start        (start),
		.pid_write    (pid_write),
		.pts_write    (pts_write),
		.pid_index    (pid_index),
		.pid_data     (pid_data),
		.pts_data     (pts_data),
		.pid_readback (pid_readback),
		.pts_readback (pts_readback),
		.pkt_ctrl     (pkt_ctrl),
		.load         (load),
		.matched_state(matched_state),
		.matched_count(matched_count)
	);

	// result: replacement data and output bytes
	packet_rewriter result_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.base_data   (base_data),
		.delayed_beat(delayed_beat),
		.pkt_ctrl    (pkt_ctrl),
		.load        (load),
		.data_write  (data_write),
		.data_index  (data_index),
		.data_word   (data_word),
		.ts_out      (ts_out)
	);

endmodule

//--- ts_replacer_tb.sv
`timescale 1ns/1ps

module ts_replacer_tb;
	import ts_pkg::*;
	import replacer_pkg::*;

	localparam ts_byte_t FILLER = 8'hff;

	logic clk = 1'b0;
	logic rst_n;
	ts_beat_t ts_in;
	logic match_enable;
	logic base_data;
	logic pid_write;
	slot_idx_t pid_index;
	pid_entry_t pid_data;
	logic pts_write;
	pts_t pts_data;
	logic data_write;
	data_addr_t data_index;
	data_word_t data_word;
	ts_beat_t ts_out;
	logic matched_state;
	logic [31:0] matched_count;
	pid_entry_t pid_readback;
	pts_t pts_readback;

	integer seed = 32'hcb3a;
	data_word_t ram_model [DATA_GROUPS * GROUP_WORDS];
	ts_byte_t sent [2][TS_PACKET_BYTES];
	logic [8:0] got [$];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int err_mark;
	pts_t pts_seen;
	logic [31:0] count_mark;

	ts_replacer dut_i (.*);

	always #50 clk = ~clk;

	// output bytes gathered with their sync flag
	always @(negedge clk) begin
		if (ts_out.valid === 1'b1) begin
			got.push_back({ts_out.sync, ts_out.data});
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) ts_out.valid |-> !$isunknown(ts_out.data))
		else begin
			errors++;
			$display("ts_out carried an unknown byte at t=%0t", $time);
		end

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("test %0d %s: pass", tests, name);
		end else begin
			$display("test %0d %s: fail, %0d errors", tests, name, errors - err_mark);
		end
	endtask

	task automatic wait_bytes(input int n);
		int t;
		t = 0;
		while (got.size() < n && t < 4 * TS_PACKET_BYTES) begin
			@(negedge clk);
			t++;
		end
		checks++;
		assert (got.size() == n) else begin
			errors++;
			$display("output stalled with %0d of %0d bytes", got.size(), n);
		end
	endtask

	task automatic set_levels(input logic m, input logic b);
		@(posedge clk);
		match_enable <= m;
		base_data <= b;
	endtask

	task automatic write_pid(input slot_idx_t slot, input pid_entry_t e);
		@(posedge clk);
		pid_write <= 1'b1;
		pid_index <= slot;
		pid_data <= e;
		@(posedge clk);
		pid_write <= 1'b0;
		@(negedge clk);
		check_value("pid_readback", e, pid_readback);
	endtask

	task automatic write_pts(input slot_idx_t slot, input pts_t v);
		@(posedge clk);
		pts_write <= 1'b1;
		pid_index <= slot;
		pts_data <= v;
		@(posedge clk);
		pts_write <= 1'b0;
		@(negedge clk);
		checks++;
		// a tick may land between the write and the read
		assert (pts_readback == v || pts_readback == v + 1'b1) else begin
			errors++;
			$display("ERROR t=%0t pts_readback expected %0h got %0h", $time, v, pts_readback);
		end
	endtask

	task automatic write_word(input data_addr_t a, input data_word_t w);
		@(posedge clk);
		data_write <= 1'b1;
		data_index <= a;
		data_word <= w;
		ram_model[a] = w;
	endtask

	task automatic read_pts(input slot_idx_t slot);
		@(posedge clk);
		pid_index <= slot;
		@(negedge clk);
		pts_seen = pts_readback;
	endtask

	task automatic drive_byte(input ts_byte_t d, input logic s);
		@(posedge clk);
		ts_in <= '{data: d, sync: s, valid: 1'b1};
	endtask

	task automatic send_packet(input int k, input ts_pid_t pid);
		for (int n = 0; n < TS_PACKET_BYTES; n++) begin
			sent[k][n] = ts_byte_t'($random(seed));
		end
		sent[k][0] = TS_SYNC_BYTE;
		sent[k][1][4:0] = pid[12:8];
		sent[k][2] = pid[7:0];
		for (int n = 0; n < TS_PACKET_BYTES; n++) begin
			drive_byte(sent[k][n], n == 0);
		end
	endtask

	// pushes the last packet bytes out of the three-deep delay
	task automatic flush_line();
		repeat (3) drive_byte(FILLER, 1'b0);
		@(posedge clk);
		ts_in <= '0;
	endtask

	function automatic ts_byte_t model_byte(input int k, input int n, input group_idx_t g,
			input logic c, input pts_t p);
		ts_byte_t o;
		ts_byte_t r;
		ts_byte_t b;
		data_word_t w;
		o = sent[k][n];
		w = ram_model[int'(g) * GROUP_WORDS + n / WORD_BYTES];
		r = w[8 * (n % WORD_BYTES) +: 8];
		case (n)
			1: b = {o[7], g == 1'b0, o[5], c ? r[4:0] : o[4:0]};
			2: b = c ? r : o;
			3: b = {o[7:6], 2'b11, o[3:0]};
			24: b = {4'b0010, p[32:30], 1'b1};
			25: b = p[29:22];
			26: b = {p[21:15], 1'b1};
			27: b = p[14:7];
			28: b = {p[6:0], 1'b1};
			default: b = r;
		endcase
		// time stamp only in group 0
		if (n >= 24 && n <= 28 && g != 1'b0) begin
			b = o;
		end
		return b;
	endfunction

	function automatic int count_mismatch(input int base, input int k, input group_idx_t g,
			input logic c, input pts_t p);
		int bad;
		bad = 0;
		for (int n = 0; n < TS_PACKET_BYTES; n++) begin
			if (got[base + n] !== {n == 0, model_byte(k, n, g, c, p)}) begin
				bad++;
			end
		end
		return bad;
	endfunction

	task automatic compare_packet(input int base, input int k, input group_idx_t g,
			input logic c, input pts_t p);
		logic [8:0] exp;
		checks++;
		assert (count_mismatch(base, k, g, c, p) == 0
			|| count_mismatch(base, k, g, c, p + 1'b1) == 0) else begin
			for (int n = 0; n < TS_PACKET_BYTES; n++) begin
				exp = {n == 0, model_byte(k, n, g, c, p)};
				if (got[base + n] !== exp) begin
					errors++;
					$display("ERROR t=%0t ts_out byte %0d expected %h got %h",
						$time, n, exp, got[base + n]);
				end
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		ts_in = '0;
		{match_enable, base_data, pid_write, pts_write, data_write} = '0;
		{pid_index, pid_data, pts_data, data_index, data_word} = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		err_mark = errors;
		@(negedge clk);
		check_value("ts_out.valid", 0, ts_out.valid);
		check_value("matched_state", 0, matched_state);
		check_value("matched_count", 0, matched_count);
		for (int i = 0; i < PID_SLOTS; i++) begin
			@(posedge clk);
			pid_index <= slot_idx_t'(i);
			@(negedge clk);
			check_value("pid_readback", 0, pid_readback);
		end
		end_test("reset state");

		err_mark = errors;
		write_pid(1, '{pid: 13'h0abc, match_en: 1'b1, change_en: 1'b1});
		write_pid(2, '{pid: 13'h0101, match_en: 1'b1, change_en: 1'b0});
		write_pid(3, '{pid: 13'h1555, match_en: 1'b0, change_en: 1'b1});
		write_pts(2, 33'h1_2345_6789);
		for (int i = 0; i < DATA_GROUPS * GROUP_WORDS; i++) begin
			write_word(data_addr_t'(i), data_word_t'($random(seed)));
		end
		@(posedge clk);
		data_write <= 1'b0;
		end_test("table and pts readback");

		// disabled slot, then a known pid with matching off
		err_mark = errors;
		got.delete();
		count_mark = matched_count;
		set_levels(1'b1, 1'b0);
		send_packet(0, 13'h1555);
		flush_line();
		set_levels(1'b0, 1'b0);
		send_packet(0, 13'h0abc);
		flush_line();
		repeat (8) @(negedge clk);
		check_value("ts_out byte count", 0, got.size());
		check_value("matched_count", count_mark, matched_count);
		check_value("matched_state", 0, matched_state);
		end_test("unmatched packets dropped");

		err_mark = errors;
		got.delete();
		count_mark = matched_count;
		set_levels(1'b1, 1'b0);
		read_pts(1);
		send_packet(0, 13'h0abc);
		send_packet(1, 13'h0abc);
		flush_line();
		wait_bytes(2 * TS_PACKET_BYTES);
		compare_packet(0, 0, 1'b0, 1'b1, pts_seen);
		compare_packet(TS_PACKET_BYTES, 1, 1'b1, 1'b1, pts_seen);
		check_value("matched_count", count_mark + 2, matched_count);
		check_value("matched_state", 1, matched_state);
		end_test("two packets with pid swap");

		err_mark = errors;
		got.delete();
		count_mark = matched_count;
		read_pts(2);
		send_packet(0, 13'h0101);
		flush_line();
		wait_bytes(TS_PACKET_BYTES);
		compare_packet(0, 0, 1'b0, 1'b0, pts_seen);
		check_value("matched_count", count_mark + 1, matched_count);
		end_test("pid kept with pts insert");

		// fillers left in the delay line come out first
		err_mark = errors;
		got.delete();
		count_mark = matched_count;
		set_levels(1'b1, 1'b1);
		send_packet(0, 13'h0abc);
		flush_line();
		wait_bytes(TS_PACKET_BYTES + 3);
		for (int i = 0; i < 3; i++) begin
			check_value("ts_out", {1'b0, FILLER}, got[i]);
		end
		for (int n = 0; n < TS_PACKET_BYTES; n++) begin
			check_value("ts_out", {n == 0, sent[0][n]}, got[n + 3]);
		end
		check_value("matched_count", count_mark, matched_count);
		set_levels(1'b1, 1'b0);
		end_test("base data pass-through");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	initial begin
		#(5_000_000);
		$display("timeout: the run did not complete in time");
		$display("Finished with errors");
		$finish;
	end

endmodule
